// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
(
   input  exec_pkg::instr_t instr,
   input  reg_pkg::word_t   opnd_a,
   input  reg_pkg::word_t   opnd_b,
   output exec_pkg::wb_t    wb
);

   // Immediate widened to a full word.
   reg_pkg::word_t imm_ext;

   assign imm_ext = {{(reg_pkg::data_width-16){1'b0}}, instr.imm};

   // ====================
   // Operation select
   // ====================

   // Default is a write to rd.
   // Jumps and calls retarget the write to R15.
   always_comb
   begin
      wb.en   = 1'b1;
      wb.addr = instr.rd;
      wb.data = '0;
      case (instr.op)
         exec_pkg::op_add:
         begin
            wb.data = opnd_a + opnd_b;
         end
         exec_pkg::op_sub:
         begin
            wb.data = opnd_a - opnd_b;
         end
         exec_pkg::op_and:
         begin
            wb.data = opnd_a & opnd_b;
         end
         exec_pkg::op_or:
         begin
            wb.data = opnd_a | opnd_b;
         end
         exec_pkg::op_xor:
         begin
            wb.data = opnd_a ^ opnd_b;
         end
         exec_pkg::op_movi:
         begin
            wb.data = imm_ext;
         end
         // Call target only, the link is handled in the register file.
         exec_pkg::op_jmp, exec_pkg::op_call:
         begin
            wb.addr = reg_pkg::pc_index;
            wb.data = opnd_a;
         end
         // Nop and undefined codes write nothing.
         default:
         begin
            wb.en = 1'b0;
         end
      endcase
   end

endmodule

// ==== design/exec_core.sv ====
`timescale 1ns/1ps

module exec_core
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               instr_valid,
   input  exec_pkg::instr_t   instr,
   input  reg_pkg::reg_addr_t dbg_addr,
   output reg_pkg::word_t     dbg_data,
   output reg_pkg::word_t     pc
);

   // Operand path.
   reg_pkg::reg_addr_t rd_a;
   reg_pkg::reg_addr_t rd_b;
   reg_pkg::word_t     data_a;
   reg_pkg::word_t     data_b;

   // Write-back path, raw and gated.
   exec_pkg::wb_t      alu_wb;
   exec_pkg::wb_t      wb;
   logic               link;
   logic               count;

   // ====================
   // Decode and issue
   // ====================

   exec_ctrl u_ctrl
   (
      .instr_valid (instr_valid),
      .instr       (instr),
      .alu_wb      (alu_wb),
      .rd_a        (rd_a),
      .rd_b        (rd_b),
      .wb          (wb),
      .link        (link),
      .count       (count)
   );

   // Result and destination.
   alu u_alu
   (
      .instr  (instr),
      .opnd_a (data_a),
      .opnd_b (data_b),
      .wb     (alu_wb)
   );

   // ====================
   // Registers and PC
   // ====================

   reg_file u_regs
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb       (wb),
      .link     (link),
      .count    (count),
      .rd_a     (rd_a),
      .rd_b     (rd_b),
      .dbg_addr (dbg_addr),
      .data_a   (data_a),
      .data_b   (data_b),
      .dbg_data (dbg_data),
      .pc       (pc)
   );

endmodule

// ==== design/exec_ctrl.sv ====
`timescale 1ns/1ps

module exec_ctrl
(
   input  logic               instr_valid,
   input  exec_pkg::instr_t   instr,
   input  exec_pkg::wb_t      alu_wb,
   output reg_pkg::reg_addr_t rd_a,
   output reg_pkg::reg_addr_t rd_b,
   output exec_pkg::wb_t      wb,
   output logic               link,
   output logic               count
);

   // ALU result targets R15.
   logic writes_pc;

   // ====================
   // Source addresses
   // ====================

   // Operands are read every cycle, valid or not.
   assign rd_a = instr.ra;
   assign rd_b = instr.rb;

   // ====================
   // Strobes
   // ====================

   assign writes_pc = alu_wb.en && (alu_wb.addr == reg_pkg::pc_index);

   // Write-back only while the instruction is valid.
   always_comb
   begin
      wb      = alu_wb;
      wb.en   = alu_wb.en && instr_valid;
   end

   // A call saves the return PC into R14.
   assign link = instr_valid && (instr.op == exec_pkg::op_call);

   // PC advances for every valid instruction that does not load it.
   // Nop counts as well.
   assign count = instr_valid && !writes_pc;

   // ====================
   // Checks
   // ====================

   // Issued instructions carry a defined opcode.
   // Settles after all inputs of the cycle have changed.
   always_comb
   begin
      if (instr_valid)
      begin
         a_op_defined : assert final (
            instr.op inside {
               exec_pkg::op_nop,
               exec_pkg::op_add,
               exec_pkg::op_sub,
               exec_pkg::op_and,
               exec_pkg::op_or,
               exec_pkg::op_xor,
               exec_pkg::op_movi,
               exec_pkg::op_jmp,
               exec_pkg::op_call
            }
         )
         else $error("exec_ctrl: undefined opcode %0d", instr.op);
      end
   end

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

   // ====================
   // Instruction format
   // ====================

   // Operation codes.
   // Values 9 to 15 are undefined.
   typedef enum logic [3:0]
   {
      op_nop  = 4'd0,
      op_add  = 4'd1,
      op_sub  = 4'd2,
      op_and  = 4'd3,
      op_or   = 4'd4,
      op_xor  = 4'd5,
      op_movi = 4'd6,
      op_jmp  = 4'd7,
      op_call = 4'd8
   } opcode_t;

   // One instruction word, 32 bits.
   // The immediate is zero-extended when used.
   typedef struct packed
   {
      opcode_t           op;
      reg_pkg::reg_addr_t rd;
      reg_pkg::reg_addr_t ra;
      reg_pkg::reg_addr_t rb;
      logic [15:0]       imm;
   } instr_t;

   // ====================
   // Write-back
   // ====================

   // Register write request, 37 bits.
   // An address of pc_index loads the PC.
   typedef struct packed
   {
      logic               en;
      reg_pkg::reg_addr_t addr;
      reg_pkg::word_t     data;
   } wb_t;

endpackage

// ==== design/pc_counter.sv ====
`timescale 1ns/1ps

module pc_counter
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           count,
   input  logic           load,
   input  reg_pkg::word_t load_data,
   output reg_pkg::word_t pc
);

   // Increment step.
   localparam reg_pkg::word_t step = 32'd1;

   // ====================
   // Counter
   // ====================

   // A load replaces the value.
   // Otherwise count advances it by one.
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pc <= '0;
      end
      else if (load)
      begin
         pc <= load_data;
      end
      else if (count)
      begin
         pc <= pc + step;
      end
   end

   // ====================
   // Checks
   // ====================

   // Control never asks to load and count in the same cycle.
   // An instruction that writes R15 must not also bump the PC.
   a_load_count_excl : assert property (
      @(posedge clk) disable iff (!arst_n)
      !(load && count)
   )
   else $error("pc_counter: load and count high together");

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
(
   input  logic               clk,
   input  logic               arst_n,
   input  exec_pkg::wb_t      wb,
   input  logic               link,
   input  logic               count,
   input  reg_pkg::reg_addr_t rd_a,
   input  reg_pkg::reg_addr_t rd_b,
   input  reg_pkg::reg_addr_t dbg_addr,
   output reg_pkg::word_t     data_a,
   output reg_pkg::word_t     data_b,
   output reg_pkg::word_t     dbg_data,
   output reg_pkg::word_t     pc
);

   // Stored registers R0 to R14.
   reg_pkg::word_t regs [0:reg_pkg::link_index];

   // Write to the array, any address but R15.
   logic arr_we;

   // Write to R15, a PC load.
   logic pc_load;

   // ====================
   // Write decode
   // ====================

   assign arr_we  = wb.en && (wb.addr != reg_pkg::pc_index);
   assign pc_load = wb.en && (wb.addr == reg_pkg::pc_index);

   // Program counter, seen as R15.
   pc_counter u_pc
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .count     (count),
      .load      (pc_load),
      .load_data (wb.data),
      .pc        (pc)
   );

   // ====================
   // Register array
   // ====================

   // Link saves the PC before the call into R14.
   // It has priority over a normal write.
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i <= int'(reg_pkg::link_index); i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (link)
      begin
         regs[reg_pkg::link_index] <= pc;
      end
      else if (arr_we)
      begin
         regs[wb.addr] <= wb.data;
      end
   end

   // ====================
   // Read ports
   // ====================

   // Address 15 returns the live PC.
   function automatic reg_pkg::word_t read_port(input reg_pkg::reg_addr_t addr);
      reg_pkg::word_t value;
      if (addr == reg_pkg::pc_index)
      begin
         value = pc;
      end
      else
      begin
         value = regs[addr];
      end
      return value;
   endfunction

   // Two operand ports and the debug port.
   always_comb
   begin
      data_a   = read_port(rd_a);
      data_b   = read_port(rd_b);
      dbg_data = read_port(dbg_addr);
   end

   // A call writes R15, so its link never meets a write to R14.
   a_link_no_r14 : assert property (
      @(posedge clk) disable iff (!arst_n)
      link |-> !(wb.en && (wb.addr == reg_pkg::link_index))
   )
   else $error("reg_file: link and R14 write in the same cycle");

endmodule

// ==== design/reg_pkg.sv ====
package reg_pkg;

   // ====================
   // Register file geometry
   // ====================

   // Width of one data word.
   localparam int data_width = 32;

   // Width of a register address.
   localparam int addr_width = 4;

   // One data word.
   typedef logic [data_width-1:0] word_t;

   // One register address, R0 to R15.
   typedef logic [addr_width-1:0] reg_addr_t;

   // R15 is the program counter and is not stored in the array.
   localparam reg_addr_t pc_index = 4'd15;

   // R14 is the link register, written by a call.
   localparam reg_addr_t link_index = 4'd14;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_exec_core -Mdir obj_dir

output=$(./obj_dir/Vtb_exec_core 2>&1 || true)
echo "$output"

if grep -q "Simulation PASSED" <<< "$output"; then
   echo "Result: pass"
   exit 0
fi
echo "Result: fail"
exit 1

// ==== sim.f ====
+incdir+include
design/reg_pkg.sv
design/exec_pkg.sv
design/pc_counter.sv
design/reg_file.sv
design/alu.sv
design/exec_ctrl.sv
design/exec_core.sv
tests/tb_exec_core.sv

// ==== include/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// ====================
// Reference model
// ====================

// Shadow copy of R0 to R14.
reg_pkg::word_t model_regs [0:14];

// Shadow copy of the program counter.
reg_pkg::word_t model_pc;

// Reset clears every register and the PC.
function automatic void model_reset();
   for (int i = 0; i < 15; i++)
   begin
      model_regs[i] = '0;
   end
   model_pc = '0;
endfunction

// Register read as the core sees it, address 15 is the PC.
function automatic reg_pkg::word_t model_read(input reg_pkg::reg_addr_t addr);
   if (addr == reg_pkg::pc_index)
   begin
      return model_pc;
   end
   return model_regs[addr];
endfunction

// One issued instruction.
// Operands come from the state before the instruction.
function automatic void model_apply(input exec_pkg::instr_t ins);
   reg_pkg::word_t     a;
   reg_pkg::word_t     b;
   reg_pkg::word_t     result;
   reg_pkg::reg_addr_t dest;
   logic               writes;
   a      = model_read(ins.ra);
   b      = model_read(ins.rb);
   result = '0;
   dest   = ins.rd;
   writes = 1'b1;
   case (ins.op)
      exec_pkg::op_add:  result = a + b;
      exec_pkg::op_sub:  result = a - b;
      exec_pkg::op_and:  result = a & b;
      exec_pkg::op_or:   result = a | b;
      exec_pkg::op_xor:  result = a ^ b;
      exec_pkg::op_movi: result = {16'h0000, ins.imm};
      exec_pkg::op_jmp, exec_pkg::op_call:
      begin
         dest   = reg_pkg::pc_index;
         result = a;
      end
      default: writes = 1'b0;
   endcase
   // A call keeps the PC it was issued at.
   if (ins.op == exec_pkg::op_call)
   begin
      model_regs[reg_pkg::link_index] = model_pc;
   end
   // Writing R15 loads the PC, anything else counts it up.
   if (writes && (dest == reg_pkg::pc_index))
   begin
      model_pc = result;
   end
   else
   begin
      if (writes)
      begin
         model_regs[dest] = result;
      end
      model_pc = model_pc + 1;
   end
endfunction

`endif

// ==== tests/tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;

   // ====================
   // Test lengths
   // ====================

   localparam int num_instr   = 400;
   localparam int sweep_every = 50;
   localparam int sweep_len   = 16;
   localparam int max_gap     = 1;
   // Instructions with gaps, ten sweeps, reset and directed cycles, then doubled.
   localparam int timeout_cycles =
      2 * (num_instr * (1 + max_gap) + (num_instr / sweep_every + 2) * sweep_len + 40);

   logic               clk;
   logic               arst_n;
   logic               instr_valid;
   exec_pkg::instr_t   instr;
   reg_pkg::reg_addr_t dbg_addr;
   reg_pkg::word_t     dbg_data;
   reg_pkg::word_t     pc;

   logic [31:0] lfsr_state;
   int          word_errors = 0;
   int          pc_errors = 0;
   int          checks = 0;
   int          cycles = 0;

   `include "core_model.svh"

   exec_core UUT
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .dbg_addr    (dbg_addr),
      .dbg_data    (dbg_data),
      .pc          (pc)
   );

   // 40 ns clock.
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   // Run limit.
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles)
      begin
         $display("Timeout: run did not end within %0d cycles", timeout_cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // ====================
   // Random source
   // ====================

   // Taps 32, 22, 2, 1.
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   // One step per bit.
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++)
      begin
         value = {value[30:0], lfsr_step()};
      end
      return value;
   endfunction

   function automatic exec_pkg::instr_t random_instr();
      exec_pkg::instr_t ins;
      logic [31:0]      raw;
      raw     = random_bits(4);
      ins.op  = exec_pkg::opcode_t'(raw[3:0] % 4'd9);
      raw     = random_bits(12);
      ins.rd  = raw[11:8];
      ins.ra  = raw[7:4];
      ins.rb  = raw[3:0];
      raw     = random_bits(16);
      ins.imm = raw[15:0];
      return ins;
   endfunction

   function automatic exec_pkg::instr_t make_instr(input exec_pkg::opcode_t op,
                                                   input logic [3:0] rd,
                                                   input logic [3:0] ra,
                                                   input logic [15:0] imm);
      exec_pkg::instr_t ins;
      ins.op  = op;
      ins.rd  = rd;
      ins.ra  = ra;
      ins.rb  = 4'd15;
      ins.imm = imm;
      return ins;
   endfunction

   // ====================
   // Checks
   // ====================

   task automatic check_word(input string name, input reg_pkg::word_t got,
                             input reg_pkg::word_t exp);
      checks++;
      if (got !== exp)
      begin
         word_errors++;
         $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pc(input reg_pkg::word_t got, input reg_pkg::word_t exp);
      checks++;
      if (got !== exp)
      begin
         pc_errors++;
         $display("ERROR t=%0t pc: got %h, expected %h", $time, got, exp);
      end
   endtask

   // Drive one cycle, check mid-cycle, then advance the model.
   task automatic run_cycle(input logic valid, input exec_pkg::instr_t ins,
                            input reg_pkg::reg_addr_t addr);
      @(posedge clk);
      instr_valid <= valid;
      instr       <= ins;
      dbg_addr    <= addr;
      @(negedge clk);
      check_pc(pc, model_pc);
      check_word($sformatf("dbg_data[R%0d]", addr), dbg_data, model_read(addr));
      if (valid)
      begin
         model_apply(ins);
      end
   endtask

   // Idle cycles reading R0 to R15.
   task automatic sweep_registers();
      for (int a = 0; a < sweep_len; a++)
      begin
         run_cycle(1'b0, '0, reg_pkg::reg_addr_t'(a));
      end
   endtask

   // ====================
   // Stimulus
   // ====================

   initial
   begin
      logic [31:0] raw;
      arst_n      = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      dbg_addr    = '0;
      lfsr_state  = 32'h5221_711d;
      model_reset();
      // Falling edge starts the asynchronous reset.
      #1 arst_n = 1'b0;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      sweep_registers();
      // Calls through R3, R14 and R15, a jump, and an add into R15.
      run_cycle(1'b1, make_instr(exec_pkg::op_movi, 4'd3, 4'd0, 16'h1234), 4'd3);
      run_cycle(1'b1, make_instr(exec_pkg::op_call, 4'd0, 4'd3, 16'h0000), 4'd14);
      run_cycle(1'b1, make_instr(exec_pkg::op_call, 4'd0, 4'd14, 16'h0000), 4'd14);
      run_cycle(1'b1, make_instr(exec_pkg::op_call, 4'd0, 4'd15, 16'h0000), 4'd15);
      run_cycle(1'b1, make_instr(exec_pkg::op_jmp, 4'd0, 4'd3, 16'h0000), 4'd14);
      run_cycle(1'b1, make_instr(exec_pkg::op_add, 4'd15, 4'd15, 16'h0000), 4'd15);
      sweep_registers();
      for (int n = 0; n < num_instr; n++)
      begin
         raw = random_bits(1);
         if (raw[0])
         begin
            raw = random_bits(4);
            run_cycle(1'b0, random_instr(), raw[3:0]);
         end
         raw = random_bits(4);
         run_cycle(1'b1, random_instr(), raw[3:0]);
         if ((n + 1) % sweep_every == 0)
         begin
            sweep_registers();
         end
      end
      $display("Checks: %0d, word errors: %0d, pc errors: %0d",
               checks, word_errors, pc_errors);
      if ((word_errors + pc_errors) == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
